// File: src.f
logic/plic_pkg.sv
logic/plic_claim_if.sv
logic/plic_regs.sv
logic/plic_gateway.sv
logic/plic_target.sv
logic/plic_top.sv
bench/plic_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = plic_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/plic_tb.sv
`timescale 1ns/100ps

module plic_tb;

    localparam int SRCS       = 8;
    localparam int TGTS       = 2;
    localparam int PW         = 3;
    localparam int CLK_PERIOD = 40;
    // About 60 APB transfers of at most 5 cycles plus reset, with wide margin
    localparam int MAX_CYCLES = 4000;

    localparam logic [23:0] PENDING_ADDR = 24'h001000;

    logic            clk;
    logic            rst_n;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [23:0]     paddr;
    logic [31:0]     pwdata;
    logic [31:0]     prdata;
    logic            pready;
    logic [SRCS:1]   irq_src;
    logic [TGTS-1:0] irq;

    int checks      = 0;
    int errors      = 0;
    int cycle_count = 0;

    // Reference model of registers and gateway flags
    logic [PW-1:0] m_prio [1:SRCS];
    logic [SRCS:1] m_enable [TGTS];
    logic [PW-1:0] m_thresh [TGTS];
    logic [SRCS:1] m_pending;
    logic [SRCS:1] m_inflight;

    plic_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .irq_src_i (irq_src),
        .irq_o     (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run passed %0d clock cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // Protocol checks
    // ----------------------------------------
    ap_pready_access: assert property (
        @(posedge clk) disable iff (!rst_n)
        pready |-> (psel && penable)
    ) else begin
        errors = errors + 1;
        $display("pready went high outside an APB access phase");
    end

    ap_reset_quiet: assert property (
        @(posedge clk) !rst_n |-> (!pready && (irq == '0))
    ) else begin
        errors = errors + 1;
        $display("pready or irq was high during reset");
    end

    // ----------------------------------------
    // Address map and model
    // ----------------------------------------
    function automatic logic [23:0] prio_addr(input int n);
        return 24'(n * 4);
    endfunction

    function automatic logic [23:0] enable_addr(input int t);
        return 24'('h2000 + t * 'h80);
    endfunction

    // Offset 0 is the threshold, offset 4 claim and complete
    function automatic logic [23:0] context_addr(input int t, input int reg_off);
        return 24'('h200000 + t * 'h1000 + reg_off);
    endfunction

    // Highest priority first, then the lowest number among equals
    function automatic int model_select(input int t);
        int top;
        top = 0;
        for (int n = 1; n <= SRCS; n++) begin
            if (m_pending[n] && m_enable[t][n] && int'(m_prio[n]) > top) begin
                top = int'(m_prio[n]);
            end
        end
        if (top <= int'(m_thresh[t])) begin
            return 0;
        end
        for (int n = 1; n <= SRCS; n++) begin
            if (m_pending[n] && m_enable[t][n] && int'(m_prio[n]) == top) begin
                return n;
            end
        end
        return 0;
    endfunction

    task automatic settle_pending();
        m_pending = m_pending | (irq_src & ~m_inflight);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks = checks + 1;
        assert (act == exp) else begin
            errors = errors + 1;
            $display("Error: %s expected 0x%0h actual 0x%0h", name, exp, act);
        end
    endtask

    // ----------------------------------------
    // APB master
    // ----------------------------------------
    task automatic bus_cycle(input logic wr, input logic [23:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waits;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        // pready is looked at a quarter period after the drive
        #(CLK_PERIOD/4);
        waits = 0;
        while (!pready) begin
            @(negedge clk);
            #(CLK_PERIOD/4);
            waits = waits + 1;
        end
        // Writes need no wait state, reads exactly one
        check_value($sformatf("%s wait states at 0x%0h", wr ? "write" : "read", addr),
                    wr ? 32'd0 : 32'd1, 32'(waits));
        rdata = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [23:0] addr, input logic [31:0] data);
        logic [31:0] ignored;
        bus_cycle(1'b1, addr, data, ignored);
    endtask

    task automatic apb_read(input logic [23:0] addr, output logic [31:0] data);
        bus_cycle(1'b0, addr, 32'h0, data);
    endtask

    task automatic read_expect(input string name, input logic [23:0] addr,
                               input logic [31:0] exp);
        logic [31:0] got;
        apb_read(addr, got);
        check_value(name, exp, got);
    endtask

    task automatic check_regs(input string name);
        for (int n = 0; n <= SRCS; n++) begin
            read_expect($sformatf("%s prio %0d", name, n), prio_addr(n),
                        (n == 0) ? 32'h0 : 32'(m_prio[n]));
        end
        for (int t = 0; t < TGTS; t++) begin
            read_expect($sformatf("%s enable %0d", name, t), enable_addr(t),
                        32'({m_enable[t], 1'b0}));
            read_expect($sformatf("%s threshold %0d", name, t), context_addr(t, 0),
                        32'(m_thresh[t]));
        end
        read_expect($sformatf("%s pending", name), PENDING_ADDR, 32'({m_pending, 1'b0}));
    endtask

    task automatic check_irq(input string name);
        for (int t = 0; t < TGTS; t++) begin
            check_value($sformatf("%s irq %0d", name, t),
                        32'(model_select(t) != 0), 32'(irq[t]));
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [31:0] data;
        int          pick;
        int          sel [TGTS];

        void'($urandom(32831));
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        irq_src    = '0;
        rst_n      = 1'b0;
        m_pending  = '0;
        m_inflight = '0;
        for (int n = 1; n <= SRCS; n++) begin
            m_prio[n] = '0;
        end
        for (int t = 0; t < TGTS; t++) begin
            m_enable[t] = '0;
            m_thresh[t] = '0;
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // Everything reads zero after reset
        check_regs("reset");
        for (int t = 0; t < TGTS; t++) begin
            read_expect($sformatf("reset claim %0d", t), context_addr(t, 4), 32'h0);
        end
        check_irq("reset");

        // Random configuration, read back through the field widths
        for (int n = 0; n <= SRCS; n++) begin
            data = $urandom;
            if (n == 0) begin
                // Source 0 has no storage, these bits must read back as zero
                data[PW-1:0] = '1;
            end
            apb_write(prio_addr(n), data);
            if (n != 0) begin
                m_prio[n] = data[PW-1:0];
            end
        end
        for (int t = 0; t < TGTS; t++) begin
            // Bit 0 set, it must read back as zero
            data = $urandom | 32'h1;
            apb_write(enable_addr(t), data);
            m_enable[t] = data[SRCS:1];
            data = $urandom;
            apb_write(context_addr(t, 0), data);
            m_thresh[t] = data[PW-1:0];
        end
        check_regs("config");

        // Random source lines show up as pending one cycle later
        irq_src = SRCS'($urandom);
        @(negedge clk);
        settle_pending();
        check_irq("lines");
        read_expect("lines pending", PENDING_ADDR, 32'({m_pending, 1'b0}));

        // All lines high, one source at top priority, then claim per target
        irq_src = '1;
        for (int t = 0; t < TGTS; t++) begin
            apb_write(enable_addr(t), 32'({{SRCS{1'b1}}, 1'b0}));
            m_enable[t] = '1;
            apb_write(context_addr(t, 0), 32'h0);
            m_thresh[t] = '0;
        end
        pick = int'($urandom_range(SRCS, 1));
        apb_write(prio_addr(pick), 32'd7);
        m_prio[pick] = 3'd7;
        settle_pending();
        for (int t = 0; t < TGTS; t++) begin
            sel[t] = model_select(t);
            read_expect($sformatf("claim %0d", t), context_addr(t, 4), 32'(sel[t]));
            if (sel[t] != 0) begin
                m_pending[sel[t]]  = 1'b0;
                m_inflight[sel[t]] = 1'b1;
            end
        end
        read_expect("in flight pending", PENDING_ADDR, 32'({m_pending, 1'b0}));
        check_irq("in flight");

        // Complete lets the held lines pend again
        for (int t = 0; t < TGTS; t++) begin
            apb_write(context_addr(t, 4), 32'(sel[t]));
            if (sel[t] != 0) begin
                m_inflight[sel[t]] = 1'b0;
            end
        end
        settle_pending();
        read_expect("complete pending", PENDING_ADDR, 32'({m_pending, 1'b0}));
        check_irq("complete");

        // Threshold at the top priority masks every source
        for (int t = 0; t < TGTS; t++) begin
            apb_write(context_addr(t, 0), 32'd7);
            m_thresh[t] = 3'd7;
        end
        check_irq("threshold");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: logic/plic_top.sv
`timescale 1ns/100ps

module plic_top #(
    parameter int SOURCE_COUNT = 8,
    parameter int TARGET_COUNT = 2,
    parameter int PRIO_WIDTH   = 3
) (
    input  logic                            clk,
    input  logic                            rst_n,

    // APB slave
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [plic_pkg::ADDR_WIDTH-1:0] paddr_i,
    input  logic [plic_pkg::BUS_WIDTH-1:0]  pwdata_i,
    output logic [plic_pkg::BUS_WIDTH-1:0]  prdata_o,
    output logic                            pready_o,

    // Interrupt sources and target lines
    input  logic [SOURCE_COUNT:1]           irq_src_i,
    output logic [TARGET_COUNT-1:0]         irq_o
);

    logic [SOURCE_COUNT:1]                   pending;
    logic [SOURCE_COUNT:1][PRIO_WIDTH-1:0]   prio;
    logic [TARGET_COUNT-1:0][SOURCE_COUNT:1] enable;
    logic [TARGET_COUNT-1:0][PRIO_WIDTH-1:0] threshold;

    plic_claim_if #(
        .SOURCE_COUNT (SOURCE_COUNT),
        .TARGET_COUNT (TARGET_COUNT)
    ) claim_bus0 ();

    plic_regs #(
        .SOURCE_COUNT (SOURCE_COUNT),
        .TARGET_COUNT (TARGET_COUNT),
        .PRIO_WIDTH   (PRIO_WIDTH)
    ) regs0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pending_i   (pending),
        .prio_o      (prio),
        .enable_o    (enable),
        .threshold_o (threshold),
        .claim_bus   (claim_bus0.regs)
    );

    plic_gateway #(
        .SOURCE_COUNT (SOURCE_COUNT),
        .TARGET_COUNT (TARGET_COUNT)
    ) gateway0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .irq_src_i (irq_src_i),
        .pending_o (pending),
        .claim_bus (claim_bus0.gateway)
    );

    plic_target #(
        .SOURCE_COUNT (SOURCE_COUNT),
        .TARGET_COUNT (TARGET_COUNT),
        .PRIO_WIDTH   (PRIO_WIDTH)
    ) target0 (
        .pending_i   (pending),
        .prio_i      (prio),
        .enable_i    (enable),
        .threshold_i (threshold),
        .irq_o       (irq_o),
        .claim_bus   (claim_bus0.target)
    );

endmodule

// File: logic/plic_target.sv
`timescale 1ns/100ps

module plic_target #(
    parameter int SOURCE_COUNT = 8,
    parameter int TARGET_COUNT = 2,
    parameter int PRIO_WIDTH   = 3
) (
    input  logic [SOURCE_COUNT:1]                   pending_i,
    input  logic [SOURCE_COUNT:1][PRIO_WIDTH-1:0]   prio_i,
    input  logic [TARGET_COUNT-1:0][SOURCE_COUNT:1] enable_i,
    input  logic [TARGET_COUNT-1:0][PRIO_WIDTH-1:0] threshold_i,
    output logic [TARGET_COUNT-1:0]                 irq_o,
    plic_claim_if.target                            claim_bus
);

    localparam int SRC_W = $clog2(SOURCE_COUNT + 1);

    logic [TARGET_COUNT-1:0][SOURCE_COUNT:1] eligible;
    logic [TARGET_COUNT-1:0][SRC_W-1:0]      best_idx;
    logic [TARGET_COUNT-1:0][PRIO_WIDTH-1:0] best_prio;

    // ----------------------------------------
    // Highest priority search per target
    // ----------------------------------------
    always_comb begin
        for (int t = 0; t < TARGET_COUNT; t++) begin
            eligible[t]  = pending_i & enable_i[t];

            // Start at the threshold so only strictly higher wins
            best_idx[t]  = '0;
            best_prio[t] = threshold_i[t];

            // Strict compare keeps the lowest source on a tie
            for (int n = 1; n <= SOURCE_COUNT; n++) begin
                if (eligible[t][n] && (prio_i[n] > best_prio[t])) begin
                    best_idx[t]  = SRC_W'(n);
                    best_prio[t] = prio_i[n];
                end
            end

            irq_o[t] = (best_idx[t] != '0);

            if (irq_o[t]) begin
                assert (pending_i[best_idx[t]] && enable_i[t][best_idx[t]]
                        && (prio_i[best_idx[t]] > threshold_i[t]))
                else $error("plic_target: target %0d selected ineligible source %0d",
                            t, best_idx[t]);
            end
        end
    end

    assign claim_bus.claim_idx = best_idx;

endmodule

// File: logic/plic_gateway.sv
`timescale 1ns/100ps

module plic_gateway #(
    parameter int SOURCE_COUNT = 8,
    parameter int TARGET_COUNT = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [SOURCE_COUNT:1] irq_src_i,
    output logic [SOURCE_COUNT:1] pending_o,
    plic_claim_if.gateway        claim_bus
);

    localparam int SRC_W = $clog2(SOURCE_COUNT + 1);

    logic [SOURCE_COUNT:1] pending_q;
    logic [SOURCE_COUNT:1] inflight_q;
    logic [SOURCE_COUNT:1] claim_hit;
    logic [SOURCE_COUNT:1] complete_hit;

    // Collect claim and complete events from all targets per source
    always_comb begin
        claim_hit    = '0;
        complete_hit = '0;
        for (int t = 0; t < TARGET_COUNT; t++) begin
            for (int n = 1; n <= SOURCE_COUNT; n++) begin
                if (claim_bus.claim_req[t] && (claim_bus.claim_idx[t] == SRC_W'(n))) begin
                    claim_hit[n] = 1'b1;
                end
                if (claim_bus.complete_req[t]
                    && (claim_bus.complete_idx[t] == SRC_W'(n))) begin
                    complete_hit[n] = 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // Pending and in-flight state
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q  <= '0;
            inflight_q <= '0;
        end else begin
            for (int n = 1; n <= SOURCE_COUNT; n++) begin
                if (claim_hit[n]) begin
                    pending_q[n]  <= 1'b0;
                    inflight_q[n] <= 1'b1;
                end else begin
                    // Level source, blocked while the handler runs
                    if (irq_src_i[n] && !inflight_q[n]) begin
                        pending_q[n] <= 1'b1;
                    end
                    if (complete_hit[n]) begin
                        inflight_q[n] <= 1'b0;
                    end
                end
            end
        end
    end

    assign pending_o = pending_q;

    // The arbiter must only hand out sources that are pending here
    for (genvar t = 0; t < TARGET_COUNT; t++) begin : g_claim_chk
        ap_claim_pending: assert property (
            @(posedge clk) disable iff (!rst_n)
            (claim_bus.claim_req[t] && (claim_bus.claim_idx[t] != '0))
                |-> pending_q[claim_bus.claim_idx[t]]
        ) else $error("plic_gateway: target %0d claimed source %0d that was not pending",
                      t, claim_bus.claim_idx[t]);
    end

endmodule

// File: logic/plic_regs.sv
`timescale 1ns/100ps

module plic_regs #(
    parameter int SOURCE_COUNT = 8,
    parameter int TARGET_COUNT = 2,
    parameter int PRIO_WIDTH   = 3
) (
    input  logic                                    clk,
    input  logic                                    rst_n,

    // APB slave
    input  logic                                    psel_i,
    input  logic                                    penable_i,
    input  logic                                    pwrite_i,
    input  logic [plic_pkg::ADDR_WIDTH-1:0]         paddr_i,
    input  logic [plic_pkg::BUS_WIDTH-1:0]          pwdata_i,
    output logic [plic_pkg::BUS_WIDTH-1:0]          prdata_o,
    output logic                                    pready_o,

    // Gateway state
    input  logic [SOURCE_COUNT:1]                   pending_i,

    // Configuration towards the arbiter
    output logic [SOURCE_COUNT:1][PRIO_WIDTH-1:0]   prio_o,
    output logic [TARGET_COUNT-1:0][SOURCE_COUNT:1] enable_o,
    output logic [TARGET_COUNT-1:0][PRIO_WIDTH-1:0] threshold_o,

    plic_claim_if.regs                              claim_bus
);

    import plic_pkg::*;

    localparam int SRC_W = $clog2(SOURCE_COUNT + 1);

    plic_offset_u                            offset;

    logic                                    access;
    logic                                    wr_en;
    logic                                    rd_first;
    logic                                    rd_wait_q;

    logic                                    word_ok;
    logic                                    prio_hit;
    logic                                    pending_hit;
    logic [TARGET_COUNT-1:0]                 enable_hit;
    logic [TARGET_COUNT-1:0]                 thresh_hit;
    logic [TARGET_COUNT-1:0]                 claim_hit;

    logic [BUS_WIDTH-1:0]                    rdata;
    logic [BUS_WIDTH-1:0]                    rdata_q;

    logic [SOURCE_COUNT:1][PRIO_WIDTH-1:0]   prio_q;
    logic [TARGET_COUNT-1:0][SOURCE_COUNT:1] enable_q;
    logic [TARGET_COUNT-1:0][PRIO_WIDTH-1:0] thresh_q;

    // ----------------------------------------
    // Bus phases
    // ----------------------------------------
    assign offset   = paddr_i;
    assign access   = psel_i & penable_i;
    assign wr_en    = access & pwrite_i;

    // First access cycle of a read, data gets registered here
    assign rd_first = access & ~pwrite_i & ~rd_wait_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_wait_q <= 1'b0;
        end else begin
            rd_wait_q <= rd_first;
        end
    end

    // Writes finish at once, reads after one wait state
    assign pready_o = access & (pwrite_i | rd_wait_q);

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    assign word_ok     = (offset.page.byte_sel == 2'b00);
    assign prio_hit    = word_ok && (offset.page.page == PRIO_BASE[ADDR_WIDTH-1:PAGE_LSB]);
    assign pending_hit = (paddr_i == PENDING_OFFSET);

    always_comb begin
        for (int t = 0; t < TARGET_COUNT; t++) begin
            enable_hit[t] = word_ok
                && (offset.page.page == ENABLE_BASE[ADDR_WIDTH-1:PAGE_LSB])
                && (offset.page.word == 10'(t * ENABLE_STRIDE / 4));
            thresh_hit[t] = (offset.ctx.area == CONTEXT_BASE[ADDR_WIDTH-1:AREA_LSB])
                && (offset.ctx.target == 9'(t))
                && (offset.ctx.reg_sel == THRESHOLD_OFFSET);
            claim_hit[t]  = (offset.ctx.area == CONTEXT_BASE[ADDR_WIDTH-1:AREA_LSB])
                && (offset.ctx.target == 9'(t))
                && (offset.ctx.reg_sel == CLAIM_OFFSET);
        end
    end

    // ----------------------------------------
    // Configuration registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio_q   <= '0;
            enable_q <= '0;
            thresh_q <= '0;
        end else if (wr_en) begin
            // Source 0 has no storage, word 0 never matches
            for (int n = 1; n <= SOURCE_COUNT; n++) begin
                if (prio_hit && (offset.page.word == 10'(n))) begin
                    prio_q[n] <= pwdata_i[PRIO_WIDTH-1:0];
                end
            end
            for (int t = 0; t < TARGET_COUNT; t++) begin
                if (enable_hit[t]) begin
                    enable_q[t] <= pwdata_i[SOURCE_COUNT:1];
                end
                if (thresh_hit[t]) begin
                    thresh_q[t] <= pwdata_i[PRIO_WIDTH-1:0];
                end
            end
        end
    end

    assign prio_o      = prio_q;
    assign enable_o    = enable_q;
    assign threshold_o = thresh_q;

    // ----------------------------------------
    // Claim and complete pulses
    // ----------------------------------------
    always_comb begin
        for (int t = 0; t < TARGET_COUNT; t++) begin
            claim_bus.claim_req[t]    = rd_first & claim_hit[t];
            claim_bus.complete_req[t] = wr_en & claim_hit[t];
            claim_bus.complete_idx[t] = pwdata_i[SRC_W-1:0];
        end
    end

    // ----------------------------------------
    // Read path
    // ----------------------------------------
    always_comb begin
        rdata = '0;
        if (prio_hit) begin
            for (int n = 1; n <= SOURCE_COUNT; n++) begin
                if (offset.page.word == 10'(n)) begin
                    rdata[PRIO_WIDTH-1:0] = prio_q[n];
                end
            end
        end
        if (pending_hit) begin
            rdata[SOURCE_COUNT:0] = {pending_i, 1'b0};
        end
        for (int t = 0; t < TARGET_COUNT; t++) begin
            if (enable_hit[t]) begin
                rdata[SOURCE_COUNT:0] = {enable_q[t], 1'b0};
            end
            if (thresh_hit[t]) begin
                rdata[PRIO_WIDTH-1:0] = thresh_q[t];
            end
            // Claim returns the arbiter's choice in the same cycle it pulses
            if (claim_hit[t]) begin
                rdata[SRC_W-1:0] = claim_bus.claim_idx[t];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (rd_first) begin
            rdata_q <= rdata;
        end
    end

    assign prdata_o = rdata_q;

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    ap_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (psel_i && penable_i) |-> $stable(paddr_i)
    ) else $error("plic_regs: paddr changed during an APB transfer");

    ap_one_claim: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(claim_bus.claim_req)
    ) else $error("plic_regs: more than one claim pulse in a cycle");

endmodule

// File: logic/plic_claim_if.sv
`timescale 1ns/100ps

interface plic_claim_if #(
    parameter int SOURCE_COUNT = 8,
    parameter int TARGET_COUNT = 2
);

    // Source number width, 0 means no source
    localparam int SRC_W = $clog2(SOURCE_COUNT + 1);

    // One-cycle pulses per target
    logic [TARGET_COUNT-1:0]            claim_req;
    logic [TARGET_COUNT-1:0]            complete_req;

    // Source numbers per target
    logic [TARGET_COUNT-1:0][SRC_W-1:0] complete_idx;
    logic [TARGET_COUNT-1:0][SRC_W-1:0] claim_idx;

    modport regs (
        output claim_req,
        output complete_req,
        output complete_idx,
        input  claim_idx
    );

    modport gateway (
        input claim_req,
        input complete_req,
        input complete_idx,
        input claim_idx
    );

    modport target (
        output claim_idx
    );

endinterface

// File: logic/plic_pkg.sv
package plic_pkg;

    // Bus data width, also caps sources at 31 plus reserved bit 0
    localparam int BUS_WIDTH  = 32;
    localparam int ADDR_WIDTH = 24;

    // Low bit of the page field and of the area field
    localparam int PAGE_LSB = 12;
    localparam int AREA_LSB = 21;

    // ----------------------------------------
    // Register map
    // ----------------------------------------
    localparam logic [ADDR_WIDTH-1:0] PRIO_BASE      = 24'h000000;
    localparam logic [ADDR_WIDTH-1:0] PENDING_OFFSET = 24'h001000;
    localparam logic [ADDR_WIDTH-1:0] ENABLE_BASE    = 24'h002000;
    localparam logic [ADDR_WIDTH-1:0] CONTEXT_BASE   = 24'h200000;

    // Byte distance between enable words of adjacent targets
    localparam int ENABLE_STRIDE = 'h80;

    // Register fields inside one target context page
    localparam logic [11:0] THRESHOLD_OFFSET = 12'h000;
    localparam logic [11:0] CLAIM_OFFSET     = 12'h004;

    // ----------------------------------------
    // Offset decode
    // ----------------------------------------
    // Page view for priority, pending and enable space,
    // context view for threshold and claim/complete
    typedef union packed {
        struct packed {
            logic [11:0] page;
            logic [9:0]  word;
            logic [1:0]  byte_sel;
        } page;
        struct packed {
            logic [2:0]  area;
            logic [8:0]  target;
            logic [11:0] reg_sel;
        } ctx;
    } plic_offset_u;

endpackage
